//--- verilog/core_pkg.sv
package core_pkg;

    localparam int unsigned XLEN = 32;
    localparam int unsigned RF_DEPTH = 32;
    localparam int unsigned PIPE_STAGES = 4;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [$clog2(RF_DEPTH)-1:0] rf_addr_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        BRANCH = 7'b1100011
    } opcode_t;

    // low three bits follow funct3, bit 3 is funct7[5]
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } alu_op_t;

    typedef enum logic {ALU_A_RS1 = 1'b0, ALU_A_PC = 1'b1} alu_a_sel_t;
    typedef enum logic {ALU_B_RS2 = 1'b0, ALU_B_IMM = 1'b1} alu_b_sel_t;
    typedef enum logic {FWD_RF = 1'b0, FWD_WBK = 1'b1} fwd_sel_t;

    // ---------------------------------------------------------------------
    // instruction word views
    typedef struct packed {
        logic [6:0] funct7;
        rf_addr_t   rs2;
        rf_addr_t   rs1;
        logic [2:0] funct3;
        rf_addr_t   rd;
        opcode_t    opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        rf_addr_t    rs1;
        logic [2:0]  funct3;
        rf_addr_t    rd;
        opcode_t     opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    // ---------------------------------------------------------------------
    // pipeline registers
    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        rf_addr_t   rs1_addr;
        rf_addr_t   rs2_addr;
        rf_addr_t   rd_addr;
        logic       rd_we;
        xlen_t      rs1_data;
        xlen_t      rs2_data;
        xlen_t      imm;
        alu_op_t    alu_op;
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
        logic       is_branch;
        logic       is_jump;
        logic [2:0] funct3;
    } dec_exe_t;

    typedef struct packed {
        logic     valid;
        rf_addr_t rd_addr;
        logic     rd_we;
        xlen_t    result;
    } exe_wbk_t;

endpackage

//--- verilog/core_pipe_ctrl.sv
`timescale 1ns/1ps

module core_pipe_ctrl #(
    parameter logic [31:0] RESET_VECTOR = 32'h0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               branch_taken_i,
    input  core_pkg::xlen_t    target_i,
    input  core_pkg::dec_exe_t exe_item_i,
    input  core_pkg::exe_wbk_t wbk_item_i,
    output core_pkg::xlen_t    fetch_pc_o,
    output logic               flush_dec_o,
    output logic               flush_exe_o,
    output logic               flush_wbk_o,
    output core_pkg::fwd_sel_t fwd_rs1_o,
    output core_pkg::fwd_sel_t fwd_rs2_o
);

    logic [core_pkg::PIPE_STAGES-2:0] reset_seq;
    core_pkg::xlen_t pc;
    core_pkg::xlen_t pc_next;
    logic wbk_writes;

    // -----------------------------------------------------------------------
    // reset sequence
    // bit 0 kills fetch into DEC, then EXE, then WBK
    always_ff @(posedge clk) begin
        if (rst) begin
            reset_seq <= '1;
        end else begin
            reset_seq <= {reset_seq[core_pkg::PIPE_STAGES-3:0], 1'b0};
        end
    end

    // -----------------------------------------------------------------------
    // program counter
    always_comb begin
        if (branch_taken_i) begin
            pc_next = target_i;
        end else if (reset_seq[0]) begin
            // hold until DEC takes the first word
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= pc_next;
        end
    end

    assign fetch_pc_o = pc;

    // taken branch kills the two younger slots
    assign flush_dec_o = reset_seq[0] || branch_taken_i;
    assign flush_exe_o = reset_seq[1] || branch_taken_i;
    assign flush_wbk_o = reset_seq[2];

    // -----------------------------------------------------------------------
    // forwarding from WBK into EXE
    assign wbk_writes = wbk_item_i.valid && wbk_item_i.rd_we && (wbk_item_i.rd_addr != '0);

    assign fwd_rs1_o = (wbk_writes && (wbk_item_i.rd_addr == exe_item_i.rs1_addr)) ?
                       core_pkg::FWD_WBK : core_pkg::FWD_RF;
    assign fwd_rs2_o = (wbk_writes && (wbk_item_i.rd_addr == exe_item_i.rs2_addr)) ?
                       core_pkg::FWD_WBK : core_pkg::FWD_RF;

endmodule

//--- verilog/core_decoder.sv
`timescale 1ns/1ps

module core_decoder (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush_dec_i,
    input  logic               flush_exe_i,
    input  core_pkg::xlen_t    pc_i,
    input  logic [31:0]        inst_i,
    input  core_pkg::xlen_t    rs1_data_i,
    input  core_pkg::xlen_t    rs2_data_i,
    output core_pkg::rf_addr_t rs1_addr_o,
    output core_pkg::rf_addr_t rs2_addr_o,
    output core_pkg::dec_exe_t exe_item_o
);

    logic dec_valid;
    core_pkg::xlen_t dec_pc;
    core_pkg::inst_u dec_inst;
    logic [31:0] raw;
    core_pkg::xlen_t imm_i, imm_b, imm_u, imm_j;
    logic use_rs1, use_rs2;
    core_pkg::dec_exe_t item;

    // DEC slot
    always_ff @(posedge clk) begin
        if (rst || flush_dec_i) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= 1'b1;
        end
        dec_pc   <= pc_i;
        dec_inst <= inst_i;
    end

    // -----------------------------------------------------------------------
    // immediate generation
    assign raw   = dec_inst;
    assign imm_i = {{20{dec_inst.i.imm[11]}}, dec_inst.i.imm};
    assign imm_b = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
    assign imm_u = {raw[31:12], 12'b0};
    assign imm_j = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};

    always_comb begin
        item           = '0;
        item.valid     = dec_valid;
        item.pc        = dec_pc;
        item.rd_addr   = dec_inst.r.rd;
        item.funct3    = dec_inst.r.funct3;
        item.alu_op    = core_pkg::ALU_ADD;
        item.alu_a_sel = core_pkg::ALU_A_RS1;
        item.alu_b_sel = core_pkg::ALU_B_IMM;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        case (dec_inst.r.opcode)
            core_pkg::OP: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                item.alu_b_sel = core_pkg::ALU_B_RS2;
                item.alu_op    = core_pkg::alu_op_t'({dec_inst.r.funct7[5], dec_inst.r.funct3});
                // funct7 bit 5 only for sub and sra
                item.rd_we = (dec_inst.r.funct7 == 7'b0000000) ||
                             ((dec_inst.r.funct7 == 7'b0100000) &&
                              (dec_inst.r.funct3 inside {3'b000, 3'b101}));
            end
            core_pkg::OP_IMM: begin
                use_rs1     = 1'b1;
                item.imm    = imm_i;
                item.alu_op = core_pkg::alu_op_t'({1'b0, dec_inst.i.funct3});
                item.rd_we  = dec_inst.i.funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
            end
            core_pkg::LUI: begin
                item.imm   = imm_u;
                item.rd_we = 1'b1;
            end
            core_pkg::JAL: begin
                item.imm       = imm_j;
                item.alu_a_sel = core_pkg::ALU_A_PC;
                item.is_jump   = 1'b1;
                item.rd_we     = 1'b1;
            end
            core_pkg::BRANCH: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                item.imm       = imm_b;
                item.alu_a_sel = core_pkg::ALU_A_PC;
                item.is_branch = 1'b1;
            end
            default: ;
        endcase
        // x0 writes are dropped here so forwarding never sees them
        if (item.rd_addr == '0) begin
            item.rd_we = 1'b0;
        end
        item.rs1_addr = use_rs1 ? dec_inst.r.rs1 : '0;
        item.rs2_addr = use_rs2 ? dec_inst.r.rs2 : '0;
    end

    assign rs1_addr_o = item.rs1_addr;
    assign rs2_addr_o = item.rs2_addr;

    // -----------------------------------------------------------------------
    // DEC/EXE register
    always_ff @(posedge clk) begin
        exe_item_o          <= item;
        exe_item_o.rs1_data <= rs1_data_i;
        exe_item_o.rs2_data <= rs2_data_i;
        if (rst || flush_exe_i) begin
            exe_item_o.valid <= 1'b0;
        end
    end

endmodule

//--- verilog/core_reg_file.sv
`timescale 1ns/1ps

module core_reg_file (
    input  logic               clk,
    input  core_pkg::rf_addr_t rs1_addr_i,
    input  core_pkg::rf_addr_t rs2_addr_i,
    input  core_pkg::exe_wbk_t wbk_item_i,
    output core_pkg::xlen_t    rs1_data_o,
    output core_pkg::xlen_t    rs2_data_o
);

    core_pkg::xlen_t regs [core_pkg::RF_DEPTH];
    logic wr_en;

    assign wr_en = wbk_item_i.valid && wbk_item_i.rd_we && (wbk_item_i.rd_addr != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wbk_item_i.rd_addr] <= wbk_item_i.result;
        end
    end

    // x0 reads zero, a same-cycle write wins over the array
    function automatic core_pkg::xlen_t read_port(core_pkg::rf_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (addr == wbk_item_i.rd_addr)) begin
            return wbk_item_i.result;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

//--- verilog/core_execute.sv
`timescale 1ns/1ps

module core_execute (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush_wbk_i,
    input  core_pkg::dec_exe_t exe_item_i,
    input  core_pkg::fwd_sel_t fwd_rs1_i,
    input  core_pkg::fwd_sel_t fwd_rs2_i,
    output logic               branch_taken_o,
    output core_pkg::xlen_t    target_o,
    output core_pkg::exe_wbk_t wbk_item_o
);

    core_pkg::xlen_t rs1_val, rs2_val;
    core_pkg::xlen_t alu_a, alu_b, alu_out;
    core_pkg::xlen_t result;
    logic cond;

    // operand forwarding from our own WBK register
    assign rs1_val = (fwd_rs1_i == core_pkg::FWD_WBK) ? wbk_item_o.result : exe_item_i.rs1_data;
    assign rs2_val = (fwd_rs2_i == core_pkg::FWD_WBK) ? wbk_item_o.result : exe_item_i.rs2_data;

    assign alu_a = (exe_item_i.alu_a_sel == core_pkg::ALU_A_PC) ? exe_item_i.pc : rs1_val;
    assign alu_b = (exe_item_i.alu_b_sel == core_pkg::ALU_B_IMM) ? exe_item_i.imm : rs2_val;

    // -----------------------------------------------------------------------
    // ALU
    always_comb begin
        case (exe_item_i.alu_op)
            core_pkg::ALU_ADD:  alu_out = alu_a + alu_b;
            core_pkg::ALU_SUB:  alu_out = alu_a - alu_b;
            core_pkg::ALU_SLL:  alu_out = alu_a << alu_b[4:0];
            core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            core_pkg::ALU_SLTU: alu_out = {31'b0, alu_a < alu_b};
            core_pkg::ALU_XOR:  alu_out = alu_a ^ alu_b;
            core_pkg::ALU_SRL:  alu_out = alu_a >> alu_b[4:0];
            core_pkg::ALU_SRA:  alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            core_pkg::ALU_OR:   alu_out = alu_a | alu_b;
            core_pkg::ALU_AND:  alu_out = alu_a & alu_b;
            default:            alu_out = '0;
        endcase
    end

    // branch compare, unsigned forms are not decoded
    always_comb begin
        case (exe_item_i.funct3)
            3'b000:  cond = (rs1_val == rs2_val);
            3'b001:  cond = (rs1_val != rs2_val);
            3'b100:  cond = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            default: cond = 1'b0;
        endcase
    end

    // branches and jal run pc + imm through the ALU
    assign target_o       = alu_out;
    assign branch_taken_o = exe_item_i.valid &&
                            (exe_item_i.is_jump || (exe_item_i.is_branch && cond));
    assign result = exe_item_i.is_jump ? (exe_item_i.pc + 32'd4) : alu_out;

    // -----------------------------------------------------------------------
    // EXE/WBK register
    always_ff @(posedge clk) begin
        if (rst || flush_wbk_i) begin
            wbk_item_o.valid <= 1'b0;
        end else begin
            wbk_item_o.valid <= exe_item_i.valid;
        end
        wbk_item_o.rd_addr <= exe_item_i.rd_addr;
        wbk_item_o.rd_we   <= exe_item_i.rd_we;
        wbk_item_o.result  <= result;
    end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top #(
    parameter logic [31:0] RESET_VECTOR = 32'h0
) (
    input  logic               clk,
    input  logic               rst,
    output core_pkg::xlen_t    imem_addr_o,
    input  logic [31:0]        imem_data_i,
    output logic               wb_valid_o,
    output core_pkg::rf_addr_t wb_rd_o,
    output core_pkg::xlen_t    wb_data_o
);

    core_pkg::xlen_t    fetch_pc;
    core_pkg::xlen_t    target;
    logic               branch_taken;
    logic               flush_dec, flush_exe, flush_wbk;
    core_pkg::fwd_sel_t fwd_rs1, fwd_rs2;
    core_pkg::rf_addr_t rs1_addr, rs2_addr;
    core_pkg::xlen_t    rs1_data, rs2_data;
    core_pkg::dec_exe_t exe_item;
    core_pkg::exe_wbk_t wbk_item;

    core_pipe_ctrl #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_pipe_ctrl (
        .clk            (clk),
        .rst            (rst),
        .branch_taken_i (branch_taken),
        .target_i       (target),
        .exe_item_i     (exe_item),
        .wbk_item_i     (wbk_item),
        .fetch_pc_o     (fetch_pc),
        .flush_dec_o    (flush_dec),
        .flush_exe_o    (flush_exe),
        .flush_wbk_o    (flush_wbk),
        .fwd_rs1_o      (fwd_rs1),
        .fwd_rs2_o      (fwd_rs2)
    );

    core_decoder u_decoder (
        .clk         (clk),
        .rst         (rst),
        .flush_dec_i (flush_dec),
        .flush_exe_i (flush_exe),
        .pc_i        (fetch_pc),
        .inst_i      (imem_data_i),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .exe_item_o  (exe_item)
    );

    core_reg_file u_reg_file (
        .clk        (clk),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wbk_item_i (wbk_item),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    core_execute u_execute (
        .clk            (clk),
        .rst            (rst),
        .flush_wbk_i    (flush_wbk),
        .exe_item_i     (exe_item),
        .fwd_rs1_i      (fwd_rs1),
        .fwd_rs2_i      (fwd_rs2),
        .branch_taken_o (branch_taken),
        .target_o       (target),
        .wbk_item_o     (wbk_item)
    );

    assign imem_addr_o = fetch_pc;

    // x0 writes already have rd_we cleared in decode
    assign wb_valid_o = wbk_item.valid && wbk_item.rd_we;
    assign wb_rd_o    = wbk_item.rd_addr;
    assign wb_data_o  = wbk_item.result;

endmodule

//--- tests/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
    input logic               clk,
    input logic               rst,
    input logic               wb_valid_i,
    input core_pkg::rf_addr_t wb_rd_i,
    input logic               branch_taken_i,
    input logic               wbk_valid_i
);

    // no retire in the four cycles after reset falls
    property no_wb_in_reset;
        @(posedge clk) $fell(rst) |->
            !wb_valid_i ##1 !wb_valid_i ##1 !wb_valid_i ##1 !wb_valid_i;
    endproperty

    property no_wb_to_x0;
        @(posedge clk) disable iff (rst) wb_valid_i |-> (wb_rd_i != '0);
    endproperty

    // slot after the branch itself, then the two killed ones
    property branch_kills_two;
        @(posedge clk) disable iff (rst)
            branch_taken_i |=> ##1 !wbk_valid_i ##1 !wbk_valid_i;
    endproperty

    a_no_wb_in_reset: assert property (no_wb_in_reset)
        else $error("writeback during reset sequence");
    a_no_wb_to_x0: assert property (no_wb_to_x0)
        else $error("writeback to x0 on retire port");
    a_branch_kills_two: assert property (branch_kills_two)
        else $error("younger slot not flushed after taken branch");

endmodule

bind core_top core_assertions u_assertions (
    .clk            (clk),
    .rst            (rst),
    .wb_valid_i     (wb_valid_o),
    .wb_rd_i        (wb_rd_o),
    .branch_taken_i (branch_taken),
    .wbk_valid_i    (wbk_item.valid)
);

//--- tests/core_tb.sv
`timescale 1ns/1ps

module core_tb;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam int TIMEOUT = 2000;

    logic               clk;
    logic               rst;
    logic [31:0]        imem_data_i;
    core_pkg::xlen_t    imem_addr;
    logic               wb_valid;
    core_pkg::rf_addr_t wb_rd;
    core_pkg::xlen_t    wb_data;

    logic [31:0] prog [256];
    int unsigned prog_len;
    logic [31:0] lfsr_state;
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [4:0]  got_rd_exp;
    logic [31:0] got_data_exp;
    int errors;
    int test_errors;
    int tests_failed;
    int tests_run;
    int writes_seen;
    logic timed_out;

    core_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data_i),
        .wb_valid_o  (wb_valid),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction memory answers in the same cycle
    always @(posedge clk) begin
        #1;
        imem_data_i = prog[imem_addr[9:2]];
    end

    // ---------------------------------------------------------------------
    // random source and instruction encoders
    function automatic logic [31:0] rand_bits(int unsigned n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int unsigned k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [4:0] src_reg();
        logic [31:0] v;
        v = rand_bits(3);
        return (v[2:0] == 3'd0) ? 5'd1 : {2'b00, v[2:0]};
    endfunction

    function automatic logic [4:0] dst_reg();
        logic [31:0] v;
        v = rand_bits(3);
        return {2'b00, v[2:0]};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {imm[11:0], rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(logic [31:0] imm, logic [4:0] rd);
        return {imm[19:0], rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] enc_b(logic [31:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [31:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic void emit(logic [31:0] w);
        prog[prog_len[7:0]] = w;
        prog_len++;
    endfunction

    function automatic logic [31:0] rand_r_op(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        int idx;
        idx = int'(rand_bits(4) % 10);
        case (idx)
            0: return enc_r(7'h00, rs2, rs1, 3'b000, rd);
            1: return enc_r(7'h20, rs2, rs1, 3'b000, rd);
            2: return enc_r(7'h00, rs2, rs1, 3'b111, rd);
            3: return enc_r(7'h00, rs2, rs1, 3'b110, rd);
            4: return enc_r(7'h00, rs2, rs1, 3'b100, rd);
            5: return enc_r(7'h00, rs2, rs1, 3'b010, rd);
            6: return enc_r(7'h00, rs2, rs1, 3'b011, rd);
            7: return enc_r(7'h00, rs2, rs1, 3'b001, rd);
            8: return enc_r(7'h00, rs2, rs1, 3'b101, rd);
            default: return enc_r(7'h20, rs2, rs1, 3'b101, rd);
        endcase
    endfunction

    function automatic logic [31:0] rand_i_op(logic [4:0] rd, logic [4:0] rs1);
        logic [2:0] f3_tab [5];
        int idx;
        f3_tab = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
        idx = int'(rand_bits(3) % 5);
        return enc_i(rand_bits(12), rs1, f3_tab[idx], rd);
    endfunction

    // ---------------------------------------------------------------------
    // program builder
    function automatic void build_program(int kind);
        logic [4:0] r;
        logic [4:0] prev;
        logic [4:0] rs1;
        logic [2:0] br_tab [4];
        logic [31:0] a;
        br_tab = '{3'b000, 3'b001, 3'b100, 3'b101};
        for (int k = 0; k < 256; k++) begin
            a = k * 4;
            // unknown opcode 0, retires as no-op
            prog[k] = {a[24:0], 7'b0000000};
        end
        prog_len = 0;
        for (int k = 1; k < 8; k++) begin
            r = k[4:0];
            emit(enc_u(rand_bits(20), r));
            emit(enc_i(rand_bits(12), r, 3'b000, r));
        end
        prev = 5'd1;
        for (int n = 0; n < 16; n++) begin
            case (kind)
                // destinations x8 to x15
                1: emit(rand_r_op(5'd8 | dst_reg(), src_reg(), src_reg()));
                2: begin
                    r = src_reg();
                    if (n % 2 == 0) begin
                        emit(rand_r_op(r, prev, dst_reg()));
                    end else begin
                        emit(rand_i_op(r, prev));
                    end
                    prev = r;
                end
                3: begin
                    if (rand_bits(1) == 32'd1) begin
                        emit(enc_u(rand_bits(20), dst_reg()));
                    end else begin
                        emit(rand_i_op(dst_reg(), src_reg()));
                    end
                end
                4: begin
                    if (rand_bits(2) == 32'd0) begin
                        rs1 = src_reg();
                        emit(enc_b((rand_bits(1) == 32'd1) ? 32'd12 : 32'd8,
                                   (rand_bits(1) == 32'd1) ? rs1 : src_reg(), rs1,
                                   br_tab[rand_bits(2) % 4]));
                    end else begin
                        emit(rand_r_op(src_reg(), src_reg(), src_reg()));
                    end
                end
                default: begin
                    if (rand_bits(2) == 32'd0) begin
                        emit(enc_j((rand_bits(1) == 32'd1) ? 32'd12 : 32'd8, dst_reg()));
                    end else begin
                        emit(rand_i_op(dst_reg(), src_reg()));
                    end
                end
            endcase
        end
        // landing pad for late branches, then the JAL-to-self loop
        for (int k = 0; k < 3; k++) begin
            emit(enc_i(32'd1, 5'd1, 3'b000, 5'd1));
        end
        emit(enc_j(32'd0, 5'd0));
    endfunction

    // ---------------------------------------------------------------------
    // ISA-level reference model
    function automatic void run_model();
        logic [31:0] regs [32];
        logic [31:0] pc, inst, a, b, val, next_pc, imm_i, imm_b, imm_j;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        wr;
        logic        cond;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        exp_rd.delete();
        exp_data.delete();
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            inst = prog[pc[9:2]];
            if (inst == enc_j(32'd0, 5'd0)) begin
                break;
            end
            rd = inst[11:7];
            f3 = inst[14:12];
            f7 = inst[31:25];
            a = regs[inst[19:15]];
            b = regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            wr = 1'b0;
            val = '0;
            next_pc = pc + 32'd4;
            case (inst[6:0])
                OPC_OP: begin
                    wr = 1'b1;
                    case ({f7, f3})
                        {7'h00, 3'b000}: val = a + b;
                        {7'h20, 3'b000}: val = a - b;
                        {7'h00, 3'b111}: val = a & b;
                        {7'h00, 3'b110}: val = a | b;
                        {7'h00, 3'b100}: val = a ^ b;
                        {7'h00, 3'b010}: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        {7'h00, 3'b011}: val = (a < b) ? 32'd1 : 32'd0;
                        {7'h00, 3'b001}: val = a << b[4:0];
                        {7'h00, 3'b101}: val = a >> b[4:0];
                        {7'h20, 3'b101}: val = $signed(a) >>> b[4:0];
                        default: wr = 1'b0;
                    endcase
                end
                OPC_OP_IMM: begin
                    wr = 1'b1;
                    case (f3)
                        3'b000: val = a + imm_i;
                        3'b010: val = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                        3'b100: val = a ^ imm_i;
                        3'b110: val = a | imm_i;
                        3'b111: val = a & imm_i;
                        default: wr = 1'b0;
                    endcase
                end
                OPC_LUI: begin
                    wr = 1'b1;
                    val = {inst[31:12], 12'b0};
                end
                OPC_JAL: begin
                    wr = 1'b1;
                    val = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                OPC_BRANCH: begin
                    case (f3)
                        3'b000: cond = (a == b);
                        3'b001: cond = (a != b);
                        3'b100: cond = ($signed(a) < $signed(b));
                        3'b101: cond = ($signed(a) >= $signed(b));
                        default: cond = 1'b0;
                    endcase
                    if (cond) begin
                        next_pc = pc + imm_b;
                    end
                end
                default: ;
            endcase
            if (wr && (rd != 5'd0)) begin
                regs[rd] = val;
                exp_rd.push_back(rd);
                exp_data.push_back(val);
            end
            pc = next_pc;
        end
    endfunction

    // ---------------------------------------------------------------------
    // compare process, sampled away from the clock edge
    always @(negedge clk) begin
        if (wb_valid === 1'b1) begin
            writes_seen++;
            if (exp_rd.size() == 0) begin
                $display("unexpected writeback at %0t: x%0d = %h", $time, wb_rd, wb_data);
                errors++;
                test_errors++;
            end else begin
                got_rd_exp = exp_rd.pop_front();
                got_data_exp = exp_data.pop_front();
                if (wb_rd !== got_rd_exp) begin
                    $display("MISMATCH at %0t: wb_rd_o expected %0d got %0d",
                             $time, got_rd_exp, wb_rd);
                    errors++;
                    test_errors++;
                end
                if (wb_data !== got_data_exp) begin
                    $display("MISMATCH at %0t: wb_data_o expected %h got %h",
                             $time, got_data_exp, wb_data);
                    errors++;
                    test_errors++;
                end
            end
        end
    end

    task automatic run_test(string name, int kind);
        int cycles;
        @(posedge clk);
        #1;
        rst = 1'b1;
        build_program(kind);
        run_model();
        test_errors = 0;
        writes_seen = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        cycles = 0;
        while ((exp_rd.size() != 0) && (cycles < TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd.size() != 0) begin
            $display("timeout in test %s: %0d writebacks missing", name, exp_rd.size());
            timed_out = 1'b1;
            tests_failed++;
        end else begin
            // quiet window, extra writes show up in the compare process
            cycles = 0;
            while (cycles < 8) begin
                @(posedge clk);
                cycles++;
            end
            $display("test %s: %0d writebacks, %0d errors", name, writes_seen, test_errors);
            if (test_errors != 0) begin
                tests_failed++;
            end
        end
        tests_run++;
    endtask

    initial begin
        string test_names [5];
        rst = 1'b1;
        imem_data_i = '0;
        lfsr_state = 32'h0a7b_4d1e;
        errors = 0;
        test_errors = 0;
        tests_failed = 0;
        tests_run = 0;
        writes_seen = 0;
        timed_out = 1'b0;
        prog_len = 0;
        exp_rd.delete();
        exp_data.delete();
        for (int k = 0; k < 256; k++) begin
            prog[k] = '0;
        end
        test_names = '{"independent_alu", "dependent_ops", "lui_immediates", "branches", "jal"};
        for (int t = 0; t < 5; t++) begin
            if (!timed_out) begin
                run_test(test_names[t], t + 1);
            end
        end
        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if ((errors == 0) && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/core_pkg.sv
verilog/core_pipe_ctrl.sv
verilog/core_decoder.sv
verilog/core_reg_file.sv
verilog/core_execute.sv
verilog/core_top.sv
tests/core_assertions.sv
tests/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module core_tb -Mdir build -o core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./build/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
